// ==== logic/vtKey_cfg.svh ====
`ifndef VTKEY_CFG_SVH
`define VTKEY_CFG_SVH

// PS/2 set-2 scancode, one byte after the E0/F0 prefixes are stripped
`define VT_SCANCODE_W 8

// Longest VT100 sequence the translator emits
// Ctrl+arrow needs six, one spare slot keeps the 56-bit content word
`define VT_MAX_SEQ 7

// Wide enough to hold VT_MAX_SEQ
`define VT_LEN_W 3

// Lead byte of every cursor and editing key sequence
`define VT_ESC 8'h1B

`endif

// ==== logic/vtKeyPkg.sv ====
`include "vtKey_cfg.svh"

package vtKeyPkg;

    // One decoded key press from the PS/2 front end
    typedef struct packed {
        logic [`VT_SCANCODE_W-1:0] scancode;
        logic                      extended;   // E0-prefixed key
        logic                      shift;      // Either shift held
        logic                      ctrl;       // Either ctrl held
    } keyEvent_t;

    // Translated byte sequence, left aligned
    typedef struct packed {
        logic [`VT_LEN_W-1:0]        length;   // Zero when unmapped
        logic [0:`VT_MAX_SEQ-1][7:0] bytes;    // Byte 0 goes out first
    } keySeq_t;

endpackage

// ==== logic/keyTranslator.sv ====
`include "vtKey_cfg.svh"

module keyTranslator (
    input  vtKeyPkg::keyEvent_t key,
    output vtKeyPkg::keySeq_t   seq
);

    logic [8:0] plain;       // {valid, char} unshifted
    logic [8:0] shifted;     // {valid, char} shifted digits and punctuation
    logic [8:0] ctrlChar;    // {valid, char} under ctrl
    logic [8:0] single;      // Final one-byte result
    logic [8:0] cursor;      // {valid, final byte} of ESC [ x keys
    logic [8:0] edit;        // {valid, digit} of ESC [ d ~ keys
    logic       isLetter;
    logic       ctrlArrow;

    always_comb begin
        unique case (key.scancode)
            8'h45: plain = {1'b1, 8'h30};   // 0
            8'h16: plain = {1'b1, 8'h31};
            8'h1E: plain = {1'b1, 8'h32};
            8'h26: plain = {1'b1, 8'h33};
            8'h25: plain = {1'b1, 8'h34};
            8'h2E: plain = {1'b1, 8'h35};
            8'h36: plain = {1'b1, 8'h36};
            8'h3D: plain = {1'b1, 8'h37};
            8'h3E: plain = {1'b1, 8'h38};
            8'h46: plain = {1'b1, 8'h39};   // 9
            8'h1C: plain = {1'b1, 8'h61};   // a
            8'h32: plain = {1'b1, 8'h62};
            8'h21: plain = {1'b1, 8'h63};
            8'h23: plain = {1'b1, 8'h64};
            8'h24: plain = {1'b1, 8'h65};
            8'h2B: plain = {1'b1, 8'h66};
            8'h34: plain = {1'b1, 8'h67};
            8'h33: plain = {1'b1, 8'h68};
            8'h43: plain = {1'b1, 8'h69};
            8'h3B: plain = {1'b1, 8'h6A};
            8'h42: plain = {1'b1, 8'h6B};
            8'h4B: plain = {1'b1, 8'h6C};
            8'h3A: plain = {1'b1, 8'h6D};
            8'h31: plain = {1'b1, 8'h6E};
            8'h44: plain = {1'b1, 8'h6F};
            8'h4D: plain = {1'b1, 8'h70};
            8'h15: plain = {1'b1, 8'h71};
            8'h2D: plain = {1'b1, 8'h72};
            8'h1B: plain = {1'b1, 8'h73};
            8'h2C: plain = {1'b1, 8'h74};
            8'h3C: plain = {1'b1, 8'h75};
            8'h2A: plain = {1'b1, 8'h76};
            8'h1D: plain = {1'b1, 8'h77};
            8'h22: plain = {1'b1, 8'h78};
            8'h35: plain = {1'b1, 8'h79};
            8'h1A: plain = {1'b1, 8'h7A};   // z
            8'h0E: plain = {1'b1, 8'h60};   // Backquote
            8'h4E: plain = {1'b1, 8'h2D};   // -
            8'h55: plain = {1'b1, 8'h3D};   // =
            8'h54: plain = {1'b1, 8'h5B};   // [
            8'h5B: plain = {1'b1, 8'h5D};   // ]
            8'h5D: plain = {1'b1, 8'h5C};   // Backslash
            8'h4C: plain = {1'b1, 8'h3B};   // ;
            8'h52: plain = {1'b1, 8'h27};   // Quote
            8'h41: plain = {1'b1, 8'h2C};   // ,
            8'h49: plain = {1'b1, 8'h2E};   // .
            8'h4A: plain = {1'b1, 8'h2F};   // /
            8'h29: plain = {1'b1, 8'h20};   // Space
            8'h5A: plain = {1'b1, 8'h0D};   // Enter
            8'h66: plain = {1'b1, 8'h08};   // Backspace
            8'h0D: plain = {1'b1, 8'h09};   // Tab
            8'h76: plain = {1'b1, `VT_ESC};
            default: plain = '0;
        endcase
    end

    // Letters are handled by clearing bit 5, so only the rest is tabled
    always_comb begin
        unique case (key.scancode)
            8'h45: shifted = {1'b1, 8'h29};   // )
            8'h16: shifted = {1'b1, 8'h21};   // !
            8'h1E: shifted = {1'b1, 8'h40};   // @
            8'h26: shifted = {1'b1, 8'h23};   // #
            8'h25: shifted = {1'b1, 8'h24};   // $
            8'h2E: shifted = {1'b1, 8'h25};   // %
            8'h36: shifted = {1'b1, 8'h5E};   // ^
            8'h3D: shifted = {1'b1, 8'h26};   // &
            8'h3E: shifted = {1'b1, 8'h2A};   // *
            8'h46: shifted = {1'b1, 8'h28};   // (
            8'h0E: shifted = {1'b1, 8'h7E};   // ~
            8'h4E: shifted = {1'b1, 8'h5F};   // _
            8'h55: shifted = {1'b1, 8'h2B};   // +
            8'h54: shifted = {1'b1, 8'h7B};   // {
            8'h5B: shifted = {1'b1, 8'h7D};   // }
            8'h5D: shifted = {1'b1, 8'h7C};   // |
            8'h4C: shifted = {1'b1, 8'h3A};   // :
            8'h52: shifted = {1'b1, 8'h22};   // Double quote
            8'h41: shifted = {1'b1, 8'h3C};   // <
            8'h49: shifted = {1'b1, 8'h3E};   // >
            8'h4A: shifted = {1'b1, 8'h3F};   // ?
            8'h29, 8'h5A, 8'h66, 8'h0D: shifted = plain;   // Whitespace unchanged
            default: shifted = '0;
        endcase
    end

    assign isLetter = plain[8] && (plain[7:0] >= 8'h61) && (plain[7:0] <= 8'h7A);

    // Control code is the low five bits of the unshifted char
    always_comb begin
        unique case (key.scancode)
            8'h29: ctrlChar = {1'b1, 8'h00};   // NUL
            8'h0E: ctrlChar = {1'b1, 8'h1E};
            8'h4A: ctrlChar = {1'b1, 8'h1F};
            8'h54, 8'h5B, 8'h5D: ctrlChar = {1'b1, 3'b000, plain[4:0]};
            default: ctrlChar = {isLetter, 3'b000, plain[4:0]};
        endcase
    end

    always_comb begin
        if (key.ctrl)
            single = ctrlChar;
        else if (key.shift && isLetter)
            single = {1'b1, plain[7:6], 1'b0, plain[4:0]};
        else if (key.shift)
            single = shifted;
        else
            single = plain;
    end

    always_comb begin
        unique case (key.scancode)
            8'h75: cursor = {1'b1, 8'h41};   // Up
            8'h72: cursor = {1'b1, 8'h42};   // Down
            8'h74: cursor = {1'b1, 8'h43};   // Right
            8'h6B: cursor = {1'b1, 8'h44};   // Left
            8'h6C: cursor = {1'b1, 8'h48};   // Home
            8'h69: cursor = {1'b1, 8'h46};   // End
            default: cursor = '0;
        endcase
    end

    always_comb begin
        unique case (key.scancode)
            8'h70: edit = {1'b1, 8'h32};   // Insert
            8'h71: edit = {1'b1, 8'h33};   // Delete
            8'h7D: edit = {1'b1, 8'h35};   // Page up
            8'h7A: edit = {1'b1, 8'h36};   // Page down
            default: edit = '0;
        endcase
    end

    // Home and End have no ctrl form
    assign ctrlArrow = cursor[8] && (cursor[7:0] <= 8'h44);

    always_comb begin
        seq = '0;
        if (!key.extended) begin
            if (single[8]) begin
                seq.length   = 3'd1;
                seq.bytes[0] = single[7:0];
            end
        end else if (key.ctrl && !key.shift) begin
            if (ctrlArrow) begin
                seq.length      = 3'd6;
                seq.bytes[0:5]  = {`VT_ESC, 8'h5B, 8'h31, 8'h3B, 8'h35, cursor[7:0]};  // ESC [1;5x
            end
        end else if (!key.shift) begin
            if (cursor[8]) begin
                seq.length     = 3'd3;
                seq.bytes[0:2] = {`VT_ESC, 8'h5B, cursor[7:0]};
            end else if (edit[8]) begin
                seq.length     = 3'd4;
                seq.bytes[0:3] = {`VT_ESC, 8'h5B, edit[7:0], 8'h7E};
            end
        end
    end

endmodule

// ==== logic/sequenceBuffer.sv ====
`include "vtKey_cfg.svh"

module sequenceBuffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  logic              shift,
    input  vtKeyPkg::keySeq_t seq,
    output logic [7:0]        txByte
);

    logic [0:`VT_MAX_SEQ-1][7:0] bytes;   // Front byte at index 0

    always_ff @(posedge clk) begin
        if (reset) begin
            bytes <= '0;
        end else if (load) begin
            bytes <= seq.bytes;
        end else if (shift) begin
            bytes <= {bytes[1:`VT_MAX_SEQ-1], 8'h00};   // Next byte to the front
        end
    end

    assign txByte = bytes[0];

endmodule

// ==== logic/byteCounter.sv ====
`include "vtKey_cfg.svh"

module byteCounter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 shift,
    input  logic [`VT_LEN_W-1:0] length,
    output logic                 lastByte
);

    logic [`VT_LEN_W-1:0] remaining;   // Bytes not yet sent

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= length;
        end else if (shift && (remaining != '0)) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign lastByte = (remaining == `VT_LEN_W'(1));

endmodule

// ==== logic/keySequencer.sv ====
module keySequencer (
    input  logic clk,
    input  logic reset,
    input  logic keyValid,
    input  logic mapped,
    input  logic txReady,
    input  logic lastByte,
    output logic keyReady,
    output logic txValid,
    output logic load,
    output logic shift
);

    typedef enum logic {
        idle,
        send
    } state_t;

    state_t state;
    state_t stateNext;

    assign keyReady = (state == idle);
    assign txValid  = (state == send);

    // Unmapped events are taken without leaving idle
    assign load  = keyReady && keyValid && mapped;
    assign shift = txValid && txReady;

    always_comb begin
        stateNext = state;
        unique case (state)
            idle: begin
                if (load)
                    stateNext = send;
            end
            send: begin
                if (shift && lastByte)
                    stateNext = idle;   // Last byte leaves this edge
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= stateNext;
        end
    end

endmodule

// ==== logic/vtKeyboard.sv ====
module vtKeyboard (
    input  logic                clk,
    input  logic                reset,
    input  vtKeyPkg::keyEvent_t key,
    input  logic                keyValid,
    output logic                keyReady,
    output logic [7:0]          txByte,
    output logic                txValid,
    input  logic                txReady
);

    vtKeyPkg::keySeq_t seq;
    logic              mapped;
    logic              load;
    logic              shift;
    logic              lastByte;

    assign mapped = (seq.length != '0);

    keyTranslator translator_i (
        .key (key),
        .seq (seq)
    );

    sequenceBuffer buffer_i (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .shift  (shift),
        .seq    (seq),
        .txByte (txByte)
    );

    byteCounter counter_i (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .shift    (shift),
        .length   (seq.length),
        .lastByte (lastByte)
    );

    keySequencer sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .keyValid (keyValid),
        .mapped   (mapped),
        .txReady  (txReady),
        .lastByte (lastByte),
        .keyReady (keyReady),
        .txValid  (txValid),
        .load     (load),
        .shift    (shift)
    );

endmodule

// ==== testbench/vtKeyboard_asserts.sv ====
`include "vtKey_cfg.svh"

module vtKeyboard_asserts (
    input logic                clk,
    input logic                reset,
    input vtKeyPkg::keyEvent_t key,
    input logic                keyValid,
    input logic                keyReady,
    input logic [7:0]          txByte,
    input logic                txValid,
    input logic                txReady
);
    timeunit 1ns;
    timeprecision 1ps;

    int                  failCount = 0;
    vtKeyPkg::keyEvent_t acceptedKey;     // Last event taken by the DUT
    logic [8:0]          expectedFirst;   // {known, first byte}
    logic                unmappedKey;

    // Single-byte results of the keys the stimulus uses
    function automatic logic [8:0] expectedChar(input vtKeyPkg::keyEvent_t ev);
        case ({ev.scancode, ev.shift, ev.ctrl})
            {8'h1C, 2'b00}: return {1'b1, 8'h61};   // a
            {8'h1C, 2'b10}: return {1'b1, 8'h41};   // A
            {8'h1C, 2'b01}: return {1'b1, 8'h01};   // Ctrl+a
            {8'h16, 2'b00}: return {1'b1, 8'h31};   // 1
            {8'h16, 2'b10}: return {1'b1, 8'h21};   // !
            default:        return 9'h000;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (keyValid && keyReady) begin
            acceptedKey <= key;
        end
    end

    assign expectedFirst = expectedChar(acceptedKey);
    assign unmappedKey   = key.extended ? key.shift : (key.scancode == 8'h05);

    resetState: assert property (@(posedge clk) $fell(reset) |-> keyReady && !txValid)
        else begin
            $error("keyReady low or txValid high after reset");
            failCount++;
        end

    firstChar: assert property (@(posedge clk) disable iff (reset)
        keyValid && keyReady && !key.extended |=>
            !txValid || !expectedFirst[8] || txByte == expectedFirst[7:0])
        else begin
            $error("ERROR txByte expected %h actual %h", $sampled(expectedFirst[7:0]),
                $sampled(txByte));
            failCount++;
        end

    escLead: assert property (@(posedge clk) disable iff (reset)
        keyValid && keyReady && key.extended |=> !txValid || txByte == `VT_ESC)
        else begin
            $error("ERROR txByte expected %h actual %h", `VT_ESC, $sampled(txByte));
            failCount++;
        end

    holdStall: assert property (@(posedge clk) disable iff (reset)
        txValid && !txReady |=> txValid && $stable(txByte))
        else begin
            $error("txByte or txValid changed while stalled");
            failCount++;
        end

    // A mapped event takes the port from ready to sending
    busy: assert property (@(posedge clk) disable iff (reset)
        keyValid && keyReady && !unmappedKey |=> txValid && !keyReady)
        else begin
            $error("keyReady high or txValid low after a mapped event");
            failCount++;
        end

    // Four quiet cycles after an unmapped event
    unmappedQuiet: assert property (@(posedge clk) disable iff (reset)
        keyValid && keyReady && unmappedKey |->
            ##1 !txValid ##1 !txValid ##1 !txValid ##1 !txValid)
        else begin
            $error("bytes sent for an unmapped event");
            failCount++;
        end

endmodule

bind vtKeyboard vtKeyboard_asserts asserts_i (
    .clk      (clk),
    .reset    (reset),
    .key      (key),
    .keyValid (keyValid),
    .keyReady (keyReady),
    .txByte   (txByte),
    .txValid  (txValid),
    .txReady  (txReady)
);

// ==== testbench/vtKeyboard_tb.sv ====
module vtKeyboard_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int waitLimit = 200;   // Cycles before a wait gives up

    logic                clk;
    logic                reset;
    vtKeyPkg::keyEvent_t key;
    logic                keyValid;
    logic                keyReady;
    logic [7:0]          txByte;
    logic                txValid;
    logic                txReady = 1'b0;
    int                  seed = 3;
    int                  rnd;
    int                  testCount;
    int                  byteErrors;
    logic                timedOut;

    vtKeyboard dut_i (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .keyValid (keyValid),
        .keyReady (keyReady),
        .txByte   (txByte),
        .txValid  (txValid),
        .txReady  (txReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        txReady <= rnd[0];   // Random back-pressure
    end

    // mods is {extended, shift, ctrl}
    function automatic vtKeyPkg::keyEvent_t makeKey(input logic [7:0] code, input logic [2:0] mods);
        vtKeyPkg::keyEvent_t ev;
        ev = {code, mods};
        return ev;
    endfunction

    task automatic runTest(input string name, input vtKeyPkg::keyEvent_t ev, input int expLen);
        int   cycles;
        int   count;
        logic accepted;
        if (timedOut) return;
        cycles   = 0;
        count    = 0;
        accepted = 1'b0;
        key      <= ev;
        keyValid <= 1'b1;
        while (!accepted && cycles < waitLimit) begin
            @(posedge clk);
            accepted = keyReady;
            cycles++;
        end
        keyValid <= 1'b0;
        if (!accepted) begin
            $display("%s: the DUT never accepted the key event", name);
            timedOut = 1'b1;
            return;
        end
        cycles = 0;
        do begin
            @(posedge clk);
            if (txValid && txReady) count++;
            cycles++;
        end while (!keyReady && cycles < waitLimit);
        if (!keyReady) begin
            $display("%s: the DUT never finished sending the sequence", name);
            timedOut = 1'b1;
            return;
        end
        repeat (4) @(posedge clk);   // Idle gap after each event
        testCount++;
        if (count != expLen) begin
            $display("ERROR byteCount expected %0h actual %0h", expLen, count);
            byteErrors++;
        end
        $display("%s: %0d bytes, %s", name, count, (count == expLen) ? "ok" : "wrong count");
    endtask

    initial begin
        reset      = 1'b1;
        key        = '0;
        keyValid   = 1'b0;
        timedOut   = 1'b0;
        testCount  = 0;
        byteErrors = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        runTest("key a", makeKey(8'h1C, 3'b000), 1);
        runTest("shift a", makeKey(8'h1C, 3'b010), 1);
        runTest("ctrl a", makeKey(8'h1C, 3'b001), 1);
        runTest("key 1", makeKey(8'h16, 3'b000), 1);
        runTest("shift 1", makeKey(8'h16, 3'b010), 1);
        runTest("arrow up", makeKey(8'h75, 3'b100), 3);
        runTest("insert", makeKey(8'h70, 3'b100), 4);
        runTest("ctrl arrow up", makeKey(8'h75, 3'b101), 6);
        runTest("unmapped 05", makeKey(8'h05, 3'b000), 0);
        runTest("shift arrow up", makeKey(8'h75, 3'b110), 0);
        $display("tests %0d, byte count errors %0d, assertion failures %0d",
            testCount, byteErrors, dut_i.asserts_i.failCount);
        if (!timedOut && byteErrors == 0 && dut_i.asserts_i.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/vtKeyPkg.sv
logic/keyTranslator.sv
logic/sequenceBuffer.sv
logic/byteCounter.sv
logic/keySequencer.sv
logic/vtKeyboard.sv
testbench/vtKeyboard_asserts.sv
testbench/vtKeyboard_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of vtKeyboard_tb
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module vtKeyboard_tb \
    -Mdir obj_dir -o vtKeyboard_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vtKeyboard_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
